//--- design/rob_cfg_pkg.sv
`default_nettype none

package rob_cfg_pkg;

    // lanes per rename group and per commit
    localparam int WAY = 2;

    localparam int ROB_DEPTH    = 16;
    localparam int ROB_ID_WIDTH = 4;

    // register number widths
    localparam int ARCH_WIDTH = 5;
    localparam int PRF_WIDTH  = 6;

    localparam int CDB_CHANNELS = 3;

    // full when fewer free slots than two groups
    localparam int FULL_THRESHOLD = 2 * WAY;

    typedef logic [ROB_ID_WIDTH-1:0] rob_id_t;
    // extra msb is the wrap bit
    typedef logic [ROB_ID_WIDTH:0]   rob_ptr_t;

endpackage

`default_nettype wire

//--- design/rob_types_pkg.sv
`default_nettype none

package rob_types_pkg;
    import rob_cfg_pkg::*;

    // one lane of a rename group
    typedef struct packed {
        logic [ARCH_WIDTH-1:0] arch;
        logic [PRF_WIDTH-1:0]  phy;
        logic                  done_at_alloc;
        logic                  br_pred_valid;
        logic                  br_pred_taken;
    } alloc_lane_t;

    // result bus channel, pc_next only meaningful for branches
    typedef struct packed {
        logic        valid;
        rob_id_t     rob_id;
        logic        is_branch;
        logic        taken;
        logic [31:0] pc_next;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        logic                  ready;
        logic [ARCH_WIDTH-1:0] arch;
        logic [PRF_WIDTH-1:0]  phy;
        logic                  br_pred_valid;
        logic                  br_pred_taken;
        logic                  br_taken;
        logic [31:0]           pc_next;
    } rob_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [ARCH_WIDTH-1:0] arch;
        logic [PRF_WIDTH-1:0]  phy;
    } commit_lane_t;

    typedef enum logic [1:0] {
        STATUS_NONE  = 2'b00,
        STATUS_EMPTY = 2'b01,
        STATUS_FULL  = 2'b10
    } rob_status_t;

endpackage

`default_nettype wire

//--- design/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module rob_alloc (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              alloc_en,
    input  rob_types_pkg::alloc_lane_t [rob_cfg_pkg::WAY-1:0] alloc_lanes,
    input  rob_cfg_pkg::rob_ptr_t                             head_ptr,
    input  logic                                              flush,
    output logic                                              wr_en,
    output rob_cfg_pkg::rob_id_t [rob_cfg_pkg::WAY-1:0]       tail_ids,
    output rob_types_pkg::alloc_lane_t [rob_cfg_pkg::WAY-1:0] wr_lanes,
    output rob_cfg_pkg::rob_ptr_t                             tail_ptr,
    output logic                                              full,
    output rob_types_pkg::rob_status_t                        status
);
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    rob_ptr_t occupancy;
    rob_ptr_t free_slots;

    // wrap bit makes a plain subtraction exact, 0..ROB_DEPTH
    assign occupancy  = tail_ptr - head_ptr;
    assign free_slots = rob_ptr_t'(ROB_DEPTH) - occupancy;
    assign full       = free_slots < rob_ptr_t'(FULL_THRESHOLD);

    always_comb begin
        if (full) begin
            status = STATUS_FULL;
        end else if (occupancy == '0) begin
            status = STATUS_EMPTY;
        end else begin
            status = STATUS_NONE;
        end
    end

    // ids handed to rename before the strobe, wrap through 4-bit add
    always_comb begin
        for (int l = 0; l < WAY; l++) begin
            tail_ids[l] = rob_id_t'(tail_ptr) + rob_id_t'(l);
        end
    end

    // the only back-pressure point
    assign wr_en    = alloc_en && !full;
    assign wr_lanes = alloc_lanes;

    // flush wins over a same-cycle allocation
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            tail_ptr <= '0;
        end else if (wr_en) begin
            tail_ptr <= tail_ptr + rob_ptr_t'(WAY);
        end
    end

endmodule

`default_nettype wire

//--- design/rob_store.sv
`timescale 1ns/1ps
`default_nettype none

module rob_store (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 wr_en,
    input  rob_cfg_pkg::rob_id_t [rob_cfg_pkg::WAY-1:0]          wr_ids,
    input  rob_types_pkg::alloc_lane_t [rob_cfg_pkg::WAY-1:0]    wr_lanes,
    input  rob_types_pkg::cdb_t [rob_cfg_pkg::CDB_CHANNELS-1:0]  cdb,
    input  rob_cfg_pkg::rob_id_t                                 head_idx,
    input  logic [rob_cfg_pkg::ROB_DEPTH-1:0]                    clr_vec,
    input  logic                                                 flush,
    output rob_types_pkg::rob_entry_t [rob_cfg_pkg::WAY-1:0]     head_window
);
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    rob_entry_t [ROB_DEPTH-1:0] entries;

    // fresh entry, already ready if the op finished at rename
    function automatic rob_entry_t make_entry(input alloc_lane_t lane);
        rob_entry_t e;
        e               = '0;
        e.valid         = 1'b1;
        e.ready         = lane.done_at_alloc;
        e.arch          = lane.arch;
        e.phy           = lane.phy;
        e.br_pred_valid = lane.br_pred_valid;
        e.br_pred_taken = lane.br_pred_taken;
        return e;
    endfunction

    // later assignments win: clear, then allocate, then completion
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            entries <= '0;
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (clr_vec[i]) begin
                    entries[i].valid <= 1'b0;
                    entries[i].ready <= 1'b0;
                end
                for (int l = 0; l < WAY; l++) begin
                    if (wr_en && (wr_ids[l] == rob_id_t'(i))) begin
                        entries[i] <= make_entry(wr_lanes[l]);
                    end
                end
                for (int c = 0; c < CDB_CHANNELS; c++) begin
                    if (cdb[c].valid && (cdb[c].rob_id == rob_id_t'(i))) begin
                        entries[i].ready <= 1'b1;
                        if (cdb[c].is_branch) begin
                            entries[i].br_taken <= cdb[c].taken;
                            entries[i].pc_next  <= cdb[c].pc_next;
                        end
                    end
                end
            end
        end
    end

    // commit window starting at the head, wraps past the last entry
    always_comb begin
        for (int w = 0; w < WAY; w++) begin
            head_window[w] = entries[rob_id_t'(head_idx + rob_id_t'(w))];
        end
    end

endmodule

`default_nettype wire

//--- design/rob_commit.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  rob_types_pkg::rob_entry_t [rob_cfg_pkg::WAY-1:0]   head_window,
    input  rob_cfg_pkg::rob_ptr_t                              tail_ptr,
    output rob_cfg_pkg::rob_ptr_t                              head_ptr,
    output rob_cfg_pkg::rob_id_t                               head_idx,
    output logic [rob_cfg_pkg::ROB_DEPTH-1:0]                  clr_vec,
    output rob_types_pkg::commit_lane_t [rob_cfg_pkg::WAY-1:0] commit_lanes,
    output logic                                               flush,
    output logic [31:0]                                        redirect_pc
);
    import rob_cfg_pkg::*;

    rob_ptr_t occupancy;
    rob_ptr_t commit_cnt;
    logic     stop;

    assign head_idx  = rob_id_t'(head_ptr);
    assign occupancy = tail_ptr - head_ptr;

    // in-order scan, ends at the first not-ready entry or a mispredict
    always_comb begin
        stop         = 1'b0;
        commit_cnt   = '0;
        clr_vec      = '0;
        commit_lanes = '0;
        flush        = 1'b0;
        redirect_pc  = '0;
        for (int w = 0; w < WAY; w++) begin
            if (!stop) begin
                if ((rob_ptr_t'(w) < occupancy) && head_window[w].valid
                        && head_window[w].ready) begin
                    commit_lanes[w].valid = 1'b1;
                    commit_lanes[w].arch  = head_window[w].arch;
                    commit_lanes[w].phy   = head_window[w].phy;
                    clr_vec[rob_id_t'(head_idx + rob_id_t'(w))] = 1'b1;
                    commit_cnt = commit_cnt + rob_ptr_t'(1);
                    // wrong direction, younger work is discarded
                    if (head_window[w].br_pred_valid
                            && (head_window[w].br_pred_taken != head_window[w].br_taken)) begin
                        flush       = 1'b1;
                        redirect_pc = head_window[w].pc_next;
                        stop        = 1'b1;
                    end
                end else begin
                    stop = 1'b1;
                end
            end
        end
    end

    // both pointers return to zero on a flush
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + commit_cnt;
        end
    end

endmodule

`default_nettype wire

//--- design/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 alloc_en,
    input  rob_types_pkg::alloc_lane_t [rob_cfg_pkg::WAY-1:0]    alloc_lanes,
    output rob_cfg_pkg::rob_id_t [rob_cfg_pkg::WAY-1:0]          tail_ids,
    input  rob_types_pkg::cdb_t [rob_cfg_pkg::CDB_CHANNELS-1:0]  cdb,
    output rob_types_pkg::commit_lane_t [rob_cfg_pkg::WAY-1:0]   commit_lanes,
    output logic                                                 flush,
    output logic [31:0]                                          redirect_pc,
    output logic                                                 full,
    output rob_types_pkg::rob_status_t                           status
);
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    logic                       wr_en;
    alloc_lane_t [WAY-1:0]      wr_lanes;
    rob_ptr_t                   head_ptr;
    rob_ptr_t                   tail_ptr;
    rob_id_t                    head_idx;
    rob_entry_t [WAY-1:0]       head_window;
    logic [ROB_DEPTH-1:0]       clr_vec;

    // producer side, owns the tail
    rob_alloc u_alloc (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_en    (alloc_en),
        .alloc_lanes (alloc_lanes),
        .head_ptr    (head_ptr),
        .flush       (flush),
        .wr_en       (wr_en),
        .tail_ids    (tail_ids),
        .wr_lanes    (wr_lanes),
        .tail_ptr    (tail_ptr),
        .full        (full),
        .status      (status)
    );

    rob_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_ids      (tail_ids),
        .wr_lanes    (wr_lanes),
        .cdb         (cdb),
        .head_idx    (head_idx),
        .clr_vec     (clr_vec),
        .flush       (flush),
        .head_window (head_window)
    );

    // consumer side, owns the head and the flush
    rob_commit u_commit (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_window  (head_window),
        .tail_ptr     (tail_ptr),
        .head_ptr     (head_ptr),
        .head_idx     (head_idx),
        .clr_vec      (clr_vec),
        .commit_lanes (commit_lanes),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

endmodule

`default_nettype wire

//--- testbench/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb;
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int TEST_COUNT  = 5;
    localparam int COMMIT_WAIT = 20;
    localparam logic [31:0] SEED = 32'hd3ee_4271;

    logic                               clk = 1'b0;
    logic                               rst_n;
    logic                               alloc_en;
    alloc_lane_t [WAY-1:0]              alloc_lanes;
    rob_id_t [WAY-1:0]                  tail_ids;
    cdb_t [CDB_CHANNELS-1:0]            cdb;
    commit_lane_t [WAY-1:0]             commit_lanes;
    logic                               flush;
    logic [31:0]                        redirect_pc;
    logic                               full;
    rob_status_t                        status;

    // reference model with plain count pointers and lanes in program order
    int          model_head;
    int          model_tail;
    alloc_lane_t exp_q[$];

    rob_top u_rob_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_en     (alloc_en),
        .alloc_lanes  (alloc_lanes),
        .tail_ids     (tail_ids),
        .cdb          (cdb),
        .commit_lanes (commit_lanes),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .full         (full),
        .status       (status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TEST_COUNT * 200 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    function automatic alloc_lane_t rand_lane();
        alloc_lane_t l;
        l      = '0;
        l.arch = ARCH_WIDTH'($urandom);
        l.phy  = PRF_WIDTH'($urandom);
        return l;
    endfunction

    function automatic cdb_t result(input int id, input logic br, input logic taken,
                                    input logic [31:0] pc);
        cdb_t c;
        c           = '0;
        c.valid     = 1'b1;
        c.rob_id    = rob_id_t'(id);
        c.is_branch = br;
        c.taken     = taken;
        c.pc_next   = pc;
        return c;
    endfunction

    // one alloc strobe that is accepted only while free slots >= threshold
    task automatic alloc_group(input alloc_lane_t l0, input alloc_lane_t l1);
        bit          accept;
        rob_status_t exp_status;
        accept = (ROB_DEPTH - (model_tail - model_head)) >= FULL_THRESHOLD;
        if (!accept) begin
            exp_status = STATUS_FULL;
        end else if (model_tail == model_head) begin
            exp_status = STATUS_EMPTY;
        end else begin
            exp_status = STATUS_NONE;
        end
        @(posedge clk);
        alloc_en       <= 1'b1;
        alloc_lanes[0] <= l0;
        alloc_lanes[1] <= l1;
        @(negedge clk);
        check_eq(32'(tail_ids[0]), 32'(model_tail % ROB_DEPTH), "tail id lane 0");
        check_eq(32'(tail_ids[1]), 32'((model_tail + 1) % ROB_DEPTH), "tail id lane 1");
        check_eq(32'(full), 32'(!accept), "full before allocation");
        check_eq(32'(status), 32'(exp_status), "status before allocation");
        @(posedge clk);
        alloc_en <= 1'b0;
        if (accept) begin
            exp_q.push_back(l0);
            exp_q.push_back(l1);
            model_tail += WAY;
        end
    endtask

    task automatic drive_cdb(input cdb_t c0, input cdb_t c1, input cdb_t c2);
        @(posedge clk);
        cdb[0] <= c0;
        cdb[1] <= c1;
        cdb[2] <= c2;
        @(posedge clk);
        cdb <= '0;
    endtask

    // waits for lane 0 to retire and checks lanes against the model
    task automatic commit_check(input int n_exp, input logic flush_exp,
                                input logic [31:0] pc_exp);
        int          waited;
        alloc_lane_t exp_lane;
        waited = 0;
        @(negedge clk);
        while (!commit_lanes[0].valid) begin
            if (waited == COMMIT_WAIT) begin
                $display("no commit appeared within %0d cycles", COMMIT_WAIT);
                $display("Simulation FAILED");
                $fatal(1, "commit timeout");
            end
            waited++;
            @(negedge clk);
        end
        check_eq(32'(commit_lanes[1].valid), 32'(n_exp == 2), "lane 1 commit valid");
        for (int w = 0; w < n_exp; w++) begin
            exp_lane = exp_q.pop_front();
            check_eq(32'(commit_lanes[w].arch), 32'(exp_lane.arch), "commit arch");
            check_eq(32'(commit_lanes[w].phy), 32'(exp_lane.phy), "commit phy");
        end
        check_eq(32'(flush), 32'(flush_exp), "flush");
        if (flush_exp) begin
            check_eq(redirect_pc, pc_exp, "redirect pc");
        end
        @(posedge clk);
        if (flush_exp) begin
            model_head = 0;
            model_tail = 0;
            exp_q.delete();
        end else begin
            model_head += n_exp;
        end
    endtask

    task automatic reset_state();
        @(negedge clk);
        check_eq(32'(commit_lanes[0].valid), 32'd0, "reset commit lane 0");
        check_eq(32'(commit_lanes[1].valid), 32'd0, "reset commit lane 1");
        check_eq(32'(flush), 32'd0, "reset flush");
        check_eq(32'(full), 32'd0, "reset full");
        check_eq(32'(status), 32'(STATUS_EMPTY), "reset status");
        check_eq(redirect_pc, 32'd0, "reset redirect pc");
        check_eq(32'(tail_ids[0]), 32'd0, "reset tail id 0");
        check_eq(32'(tail_ids[1]), 32'd1, "reset tail id 1");
    endtask

    task automatic out_of_order_complete();
        int base;
        base = model_tail;
        alloc_group(rand_lane(), rand_lane());
        // younger lane finishes first
        drive_cdb(result(base + 1, 1'b0, 1'b0, 32'd0), '0, '0);
        repeat (2) begin
            @(negedge clk);
            check_eq(32'(commit_lanes[0].valid), 32'd0, "commit while lane 0 pending");
            check_eq(32'(commit_lanes[1].valid), 32'd0, "lane 1 commit while lane 0 pending");
        end
        drive_cdb(result(base, 1'b0, 1'b0, 32'd0), '0, '0);
        commit_check(2, 1'b0, 32'd0);
    endtask

    task automatic fill_and_wrap();
        while ((ROB_DEPTH - (model_tail - model_head)) >= FULL_THRESHOLD) begin
            alloc_group(rand_lane(), rand_lane());
        end
        @(negedge clk);
        check_eq(32'(full), 32'd1, "full after fill");
        check_eq(32'(status), 32'(STATUS_FULL), "status after fill");
        // rejected strobe
        alloc_group(rand_lane(), rand_lane());
        @(negedge clk);
        check_eq(32'(tail_ids[0]), 32'(model_tail % ROB_DEPTH), "tail id after reject");
        drive_cdb(result(model_head, 1'b0, 1'b0, 32'd0),
                  result(model_head + 1, 1'b0, 1'b0, 32'd0), '0);
        commit_check(2, 1'b0, 32'd0);
        @(negedge clk);
        check_eq(32'(full), 32'd0, "full after commit");
        // this group takes ids past 15
        alloc_group(rand_lane(), rand_lane());
        while (model_tail != model_head) begin
            drive_cdb(result(model_head, 1'b0, 1'b0, 32'd0),
                      result(model_head + 1, 1'b0, 1'b0, 32'd0), '0);
            commit_check(2, 1'b0, 32'd0);
        end
        @(negedge clk);
        check_eq(32'(status), 32'(STATUS_EMPTY), "status after drain");
    endtask

    task automatic mispredict_flush();
        alloc_lane_t br;
        int          base;
        br               = rand_lane();
        br.br_pred_valid = 1'b1;
        br.br_pred_taken = 1'b0;
        base             = model_tail;
        alloc_group(br, rand_lane());
        alloc_group(rand_lane(), rand_lane());
        drive_cdb(result(base + 1, 1'b0, 1'b0, 32'd0),
                  result(base + 2, 1'b0, 1'b0, 32'd0),
                  result(base + 3, 1'b0, 1'b0, 32'd0));
        @(negedge clk);
        check_eq(32'(commit_lanes[0].valid), 32'd0, "commit before branch resolves");
        check_eq(32'(commit_lanes[1].valid), 32'd0, "lane 1 commit before branch resolves");
        drive_cdb(result(base, 1'b1, 1'b1, 32'h8000_1a40), '0, '0);
        commit_check(1, 1'b1, 32'h8000_1a40);
        @(negedge clk);
        check_eq(32'(status), 32'(STATUS_EMPTY), "status after flush");
        check_eq(32'(tail_ids[0]), 32'd0, "tail id 0 after flush");
        check_eq(32'(tail_ids[1]), 32'd1, "tail id 1 after flush");
        check_eq(32'(commit_lanes[0].valid), 32'd0, "commit after flush");
    endtask

    task automatic good_branch_and_early_done();
        alloc_lane_t da0;
        alloc_lane_t da1;
        alloc_lane_t br;
        int          base;
        da0               = rand_lane();
        da0.done_at_alloc = 1'b1;
        da1               = rand_lane();
        da1.done_at_alloc = 1'b1;
        alloc_group(da0, da1);
        // no result-bus strobe for these
        commit_check(2, 1'b0, 32'd0);
        br               = rand_lane();
        br.br_pred_valid = 1'b1;
        br.br_pred_taken = 1'b1;
        base             = model_tail;
        alloc_group(br, rand_lane());
        drive_cdb(result(base, 1'b1, 1'b1, 32'h0000_2f00),
                  result(base + 1, 1'b0, 1'b0, 32'd0), '0);
        commit_check(2, 1'b0, 32'd0);
        @(negedge clk);
        check_eq(32'(status), 32'(STATUS_EMPTY), "status after branch commit");
    endtask

    initial begin
        void'($urandom(SEED));
        model_head = 0;
        model_tail = 0;
        rst_n       <= 1'b0;
        alloc_en    <= 1'b0;
        alloc_lanes <= '0;
        cdb         <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        reset_state();
        out_of_order_complete();
        fill_and_wrap();
        mispredict_flush();
        good_branch_and_early_done();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
design/rob_cfg_pkg.sv
design/rob_types_pkg.sv
design/rob_alloc.sv
design/rob_store.sv
design/rob_commit.sv
design/rob_top.sv
testbench/rob_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the reorder buffer testbench, exit status follows the run
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ps -f all.f \
        --top-module rob_tb -o rob_sim \
    && ./obj_dir/rob_sim \
    || exit 1
